// File: src/ctrl_cfg.svh
// Width settings for the multicycle RV32I control unit.
// Include this wherever a port or constant needs one of these widths.
// The package holds the types built on top of these.

`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

`define CTRL_OPCODE_W 7   // instr[6:0]
`define CTRL_FUNCT7_W 7   // instr[31:25]
`define CTRL_CAUSE_W  32  // mcause width

`endif

// File: src/ctrl_pkg.sv
// Shared types and constants for the multicycle RV32I control unit.
// Holds the FSM state encoding, the datapath select encodings, the
// opcodes, the trap cause codes and the control word handed to the top.
// Referenced everywhere by scoped names.

`include "ctrl_cfg.svh"

package ctrl_pkg;

    // encodings are contiguous, each trap1 directly follows its trap0
    typedef enum logic [4:0] {
        S_FETCH, S_DECODE,
        S_MEM_ADDR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE,
        S_EXEC_R, S_EXEC_I, S_ALU_WB,
        S_JAL, S_JALR, S_BRANCH, S_LUI, S_AUIPC,
        S_ILLEGAL0, S_ILLEGAL1,
        S_LOAD_MISALIGN0, S_LOAD_MISALIGN1,
        S_STORE_MISALIGN0, S_STORE_MISALIGN1,
        S_LOAD_FAULT0, S_LOAD_FAULT1,
        S_STORE_FAULT0, S_STORE_FAULT1
    } ctrl_state_t;

    typedef enum logic {ADR_PC, ADR_RESULT} adr_src_t;

    typedef enum logic [1:0] {SRCA_PC, SRCA_OLD_PC, SRCA_RD1_BUF} alu_src_a_t;

    typedef enum logic [1:0] {SRCB_RD2_BUF, SRCB_IMM_EXT, SRCB_CONST_4} alu_src_b_t;

    typedef enum logic [2:0] {
        ALU_OP_ADD, ALU_OP_ARITH_LOGIC, ALU_OP_BRANCH, ALU_OP_LUI, ALU_OP_AUIPC
    } alu_op_t;

    typedef enum logic [1:0] {RESULT_ALUOUT, RESULT_DATA, RESULT_ALURESULT} result_src_t;

    typedef enum logic [2:0] {IMM_R, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_t;

    // all-zero word means pc/rd2/add/aluout with every strobe off
    typedef struct packed {
        adr_src_t    adr_src;
        logic        fetched_instr;
        logic        instr_retired;
        alu_src_a_t  alu_src_a;
        alu_src_b_t  alu_src_b;
        alu_op_t     alu_op;
        result_src_t result_src;
        logic        pc_update;
        logic        branch;
        logic        reg_write;
        logic        mem_write;
        logic        mem_valid;
        logic        exception_event;
    } ctrl_word_t;

    localparam logic [`CTRL_OPCODE_W-1:0] OP_LOAD   = 7'b000_0011;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_STORE  = 7'b010_0011;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_RTYPE  = 7'b011_0011;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_ITYPE  = 7'b001_0011;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_JAL    = 7'b110_1111;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_JALR   = 7'b110_0111;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_BRANCH = 7'b110_0011;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_LUI    = 7'b011_0111;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_AUIPC  = 7'b001_0111;
    localparam logic [`CTRL_OPCODE_W-1:0] OP_FENCE  = 7'b000_1111;

    // synchronous exception codes, as in mcause
    localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_ILLEGAL        = 'd2;
    localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_LOAD_MISALIGN  = 'd4;
    localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_LOAD_FAULT     = 'd5;
    localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_STORE_MISALIGN = 'd6;
    localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_STORE_FAULT    = 'd7;

endpackage

// File: src/instr_class_if.sv
// Decoded instruction class, passed from the decoder to the sequencer.
// One-hot levels, combinational from the current opcode.

`timescale 1ns/10ps

interface instr_class_if;
    logic is_load;
    logic is_store;
    logic is_alu_r;
    logic is_alu_i;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic is_lui;
    logic is_auipc;
    logic is_fence;
    logic is_illegal;  // unknown opcode or M-extension r-type

    modport decoder (
        output is_load, is_store, is_alu_r, is_alu_i, is_jal, is_jalr,
               is_branch, is_lui, is_auipc, is_fence, is_illegal
    );

    modport sequencer (
        input is_load, is_store, is_alu_r, is_alu_i, is_jal, is_jalr,
              is_branch, is_lui, is_auipc, is_fence, is_illegal
    );
endinterface

// File: src/instr_decoder.sv
// Opcode classifier for the multicycle control unit.
// Raises exactly one class flag for the current instruction and picks
// the immediate format. Purely combinational.

`timescale 1ns/10ps
`include "ctrl_cfg.svh"

module instr_decoder (
    input  logic [`CTRL_OPCODE_W-1:0] op,
    input  logic [`CTRL_FUNCT7_W-1:0] funct7,
    instr_class_if.decoder            cls,
    output ctrl_pkg::imm_src_t        imm_src
);

    always_comb begin
        cls.is_load    = 1'b0;
        cls.is_store   = 1'b0;
        cls.is_alu_r   = 1'b0;
        cls.is_alu_i   = 1'b0;
        cls.is_jal     = 1'b0;
        cls.is_jalr    = 1'b0;
        cls.is_branch  = 1'b0;
        cls.is_lui     = 1'b0;
        cls.is_auipc   = 1'b0;
        cls.is_fence   = 1'b0;
        cls.is_illegal = 1'b0;
        case (op)
            ctrl_pkg::OP_LOAD:   cls.is_load   = 1'b1;
            ctrl_pkg::OP_STORE:  cls.is_store  = 1'b1;
            ctrl_pkg::OP_ITYPE:  cls.is_alu_i  = 1'b1;
            ctrl_pkg::OP_JAL:    cls.is_jal    = 1'b1;
            ctrl_pkg::OP_JALR:   cls.is_jalr   = 1'b1;
            ctrl_pkg::OP_BRANCH: cls.is_branch = 1'b1;
            ctrl_pkg::OP_LUI:    cls.is_lui    = 1'b1;
            ctrl_pkg::OP_AUIPC:  cls.is_auipc  = 1'b1;
            ctrl_pkg::OP_FENCE:  cls.is_fence  = 1'b1;
            ctrl_pkg::OP_RTYPE: begin
                // no mul/div unit behind this fsm
                if (funct7[0]) cls.is_illegal = 1'b1;
                else           cls.is_alu_r   = 1'b1;
            end
            default:             cls.is_illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (op)
            ctrl_pkg::OP_ITYPE,
            ctrl_pkg::OP_JALR,
            ctrl_pkg::OP_LOAD:   imm_src = ctrl_pkg::IMM_I;
            ctrl_pkg::OP_STORE:  imm_src = ctrl_pkg::IMM_S;
            ctrl_pkg::OP_BRANCH: imm_src = ctrl_pkg::IMM_B;
            ctrl_pkg::OP_LUI,
            ctrl_pkg::OP_AUIPC:  imm_src = ctrl_pkg::IMM_U;
            ctrl_pkg::OP_JAL:    imm_src = ctrl_pkg::IMM_J;
            default:             imm_src = ctrl_pkg::IMM_R;  // r-type, fence, illegal
        endcase
    end

endmodule

// File: src/state_sequencer.sv
// State register and next-state logic of the multicycle control FSM.
// Steps one state per clock through fetch, decode, execute and write-back.
// Memory states hold until mem_ready. Address faults and misalignment
// are resolved in the address state and divert to a two-cycle trap.

`timescale 1ns/10ps

module state_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    instr_class_if.sequencer      cls,
    input  logic                  mem_ready,
    input  logic                  unaligned_access_load,
    input  logic                  unaligned_access_store,
    input  logic                  access_fault,
    output ctrl_pkg::ctrl_state_t state
);

    ctrl_pkg::ctrl_state_t next_state;
    logic                  mem_is_store;  // latched class for the address state

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ctrl_pkg::S_FETCH;
            mem_is_store <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ctrl_pkg::S_DECODE)
                mem_is_store <= cls.is_store;
        end
    end

    always_comb begin
        next_state = ctrl_pkg::S_FETCH;
        case (state)
            ctrl_pkg::S_FETCH: next_state = mem_ready ? ctrl_pkg::S_DECODE : ctrl_pkg::S_FETCH;
            ctrl_pkg::S_DECODE: begin
                case (1'b1)
                    cls.is_load,
                    cls.is_store:   next_state = ctrl_pkg::S_MEM_ADDR;
                    cls.is_alu_r:   next_state = ctrl_pkg::S_EXEC_R;
                    cls.is_alu_i:   next_state = ctrl_pkg::S_EXEC_I;
                    cls.is_jal:     next_state = ctrl_pkg::S_JAL;
                    cls.is_jalr:    next_state = ctrl_pkg::S_JALR;
                    cls.is_branch:  next_state = ctrl_pkg::S_BRANCH;
                    cls.is_lui:     next_state = ctrl_pkg::S_LUI;
                    cls.is_auipc:   next_state = ctrl_pkg::S_AUIPC;
                    cls.is_fence:   next_state = ctrl_pkg::S_FETCH;  // no-op
                    cls.is_illegal: next_state = ctrl_pkg::S_ILLEGAL0;
                    default:        next_state = ctrl_pkg::S_ILLEGAL0;
                endcase
            end
            ctrl_pkg::S_MEM_ADDR: begin
                // access fault wins over misalignment
                if (mem_is_store)
                    next_state = access_fault ? ctrl_pkg::S_STORE_FAULT0 :
                                 unaligned_access_store ? ctrl_pkg::S_STORE_MISALIGN0 :
                                 ctrl_pkg::S_MEM_WRITE;
                else
                    next_state = access_fault ? ctrl_pkg::S_LOAD_FAULT0 :
                                 unaligned_access_load ? ctrl_pkg::S_LOAD_MISALIGN0 :
                                 ctrl_pkg::S_MEM_READ;
            end
            ctrl_pkg::S_MEM_READ:  next_state = mem_ready ? ctrl_pkg::S_MEM_WB : ctrl_pkg::S_MEM_READ;
            ctrl_pkg::S_MEM_WRITE: next_state = mem_ready ? ctrl_pkg::S_FETCH : ctrl_pkg::S_MEM_WRITE;
            ctrl_pkg::S_EXEC_R,
            ctrl_pkg::S_EXEC_I,
            ctrl_pkg::S_LUI,
            ctrl_pkg::S_AUIPC,
            ctrl_pkg::S_JAL:       next_state = ctrl_pkg::S_ALU_WB;
            ctrl_pkg::S_JALR:      next_state = ctrl_pkg::S_JAL;  // target first, then link
            ctrl_pkg::S_ILLEGAL0:        next_state = ctrl_pkg::S_ILLEGAL1;
            ctrl_pkg::S_LOAD_MISALIGN0:  next_state = ctrl_pkg::S_LOAD_MISALIGN1;
            ctrl_pkg::S_STORE_MISALIGN0: next_state = ctrl_pkg::S_STORE_MISALIGN1;
            ctrl_pkg::S_LOAD_FAULT0:     next_state = ctrl_pkg::S_LOAD_FAULT1;
            ctrl_pkg::S_STORE_FAULT0:    next_state = ctrl_pkg::S_STORE_FAULT1;
            default:               next_state = ctrl_pkg::S_FETCH;  // wb, branch, trap1
        endcase
    end

    // legal encodings are contiguous up to the last trap state
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state <= ctrl_pkg::S_STORE_FAULT1);

    // every trap announcement is followed by its pc redirect
    a_trap_pair: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {ctrl_pkg::S_ILLEGAL0, ctrl_pkg::S_LOAD_MISALIGN0,
                      ctrl_pkg::S_STORE_MISALIGN0, ctrl_pkg::S_LOAD_FAULT0,
                      ctrl_pkg::S_STORE_FAULT0}
        |=> state == $past(state) + 5'd1);

    a_decode_once: assert property (@(posedge clk) disable iff (!rst_n)
        state == ctrl_pkg::S_DECODE |=> state != ctrl_pkg::S_DECODE);

endmodule

// File: src/control_word_gen.sv
// Datapath control word for each FSM state.
// Combinational from the current state, with zero and mem_ready folded
// in where a strobe depends on them. Also supplies the trap cause,
// which is nonzero only while exception_event is high.

`timescale 1ns/10ps
`include "ctrl_cfg.svh"

module control_word_gen (
    input  ctrl_pkg::ctrl_state_t   state,
    input  logic                    zero,
    input  logic                    mem_ready,
    output ctrl_pkg::ctrl_word_t    ctrl,
    output logic [`CTRL_CAUSE_W-1:0] cause
);

    always_comb begin
        ctrl  = '0;
        cause = '0;
        case (state)
            ctrl_pkg::S_FETCH: begin
                // instr <- mem[pc], pc <- pc + 4
                ctrl.mem_valid     = 1'b1;
                ctrl.adr_src       = ctrl_pkg::ADR_PC;
                ctrl.alu_src_a     = ctrl_pkg::SRCA_PC;
                ctrl.alu_src_b     = ctrl_pkg::SRCB_CONST_4;
                ctrl.result_src    = ctrl_pkg::RESULT_ALURESULT;
                ctrl.fetched_instr = mem_ready;
                ctrl.pc_update     = mem_ready;
            end
            ctrl_pkg::S_DECODE: begin
                ctrl.alu_src_a = ctrl_pkg::SRCA_OLD_PC;  // branch target into aluout
                ctrl.alu_src_b = ctrl_pkg::SRCB_IMM_EXT;
            end
            ctrl_pkg::S_MEM_ADDR,
            ctrl_pkg::S_JALR: begin
                ctrl.alu_src_a = ctrl_pkg::SRCA_RD1_BUF;  // rs1 + imm
                ctrl.alu_src_b = ctrl_pkg::SRCB_IMM_EXT;
            end
            ctrl_pkg::S_MEM_READ: begin
                ctrl.mem_valid = 1'b1;
                ctrl.adr_src   = ctrl_pkg::ADR_RESULT;
            end
            ctrl_pkg::S_MEM_WB: begin
                ctrl.mem_valid     = 1'b1;
                ctrl.result_src    = ctrl_pkg::RESULT_DATA;
                ctrl.reg_write     = 1'b1;
                ctrl.instr_retired = 1'b1;
            end
            ctrl_pkg::S_MEM_WRITE: begin
                ctrl.mem_valid     = 1'b1;
                ctrl.adr_src       = ctrl_pkg::ADR_RESULT;
                ctrl.mem_write     = 1'b1;
                ctrl.instr_retired = mem_ready;  // counts once the write lands
            end
            ctrl_pkg::S_EXEC_R: begin
                ctrl.alu_src_a = ctrl_pkg::SRCA_RD1_BUF;
                ctrl.alu_src_b = ctrl_pkg::SRCB_RD2_BUF;
                ctrl.alu_op    = ctrl_pkg::ALU_OP_ARITH_LOGIC;
            end
            ctrl_pkg::S_EXEC_I: begin
                ctrl.alu_src_a = ctrl_pkg::SRCA_RD1_BUF;
                ctrl.alu_src_b = ctrl_pkg::SRCB_IMM_EXT;
                ctrl.alu_op    = ctrl_pkg::ALU_OP_ARITH_LOGIC;
            end
            ctrl_pkg::S_ALU_WB: begin
                ctrl.mem_valid     = 1'b1;  // overlaps next fetch request
                ctrl.reg_write     = 1'b1;
                ctrl.instr_retired = 1'b1;
            end
            ctrl_pkg::S_JAL: begin
                // pc <- aluout, link value old_pc + 4 goes to aluout
                ctrl.alu_src_a = ctrl_pkg::SRCA_OLD_PC;
                ctrl.alu_src_b = ctrl_pkg::SRCB_CONST_4;
                ctrl.pc_update = 1'b1;
            end
            ctrl_pkg::S_BRANCH: begin
                ctrl.alu_src_a     = ctrl_pkg::SRCA_RD1_BUF;
                ctrl.alu_src_b     = ctrl_pkg::SRCB_RD2_BUF;
                ctrl.alu_op        = ctrl_pkg::ALU_OP_BRANCH;
                ctrl.branch        = 1'b1;
                ctrl.mem_valid     = zero;
                ctrl.instr_retired = 1'b1;
            end
            ctrl_pkg::S_LUI: begin
                ctrl.alu_src_b = ctrl_pkg::SRCB_IMM_EXT;  // src a ignored
                ctrl.alu_op    = ctrl_pkg::ALU_OP_LUI;
            end
            ctrl_pkg::S_AUIPC: begin
                ctrl.alu_src_a = ctrl_pkg::SRCA_OLD_PC;
                ctrl.alu_src_b = ctrl_pkg::SRCB_IMM_EXT;
                ctrl.alu_op    = ctrl_pkg::ALU_OP_AUIPC;
            end
            ctrl_pkg::S_ILLEGAL0,
            ctrl_pkg::S_LOAD_MISALIGN0,
            ctrl_pkg::S_STORE_MISALIGN0,
            ctrl_pkg::S_LOAD_FAULT0,
            ctrl_pkg::S_STORE_FAULT0: begin
                ctrl.exception_event = 1'b1;
                case (state)
                    ctrl_pkg::S_ILLEGAL0:        cause = ctrl_pkg::CAUSE_ILLEGAL;
                    ctrl_pkg::S_LOAD_MISALIGN0:  cause = ctrl_pkg::CAUSE_LOAD_MISALIGN;
                    ctrl_pkg::S_STORE_MISALIGN0: cause = ctrl_pkg::CAUSE_STORE_MISALIGN;
                    ctrl_pkg::S_LOAD_FAULT0:     cause = ctrl_pkg::CAUSE_LOAD_FAULT;
                    default:                     cause = ctrl_pkg::CAUSE_STORE_FAULT;
                endcase
            end
            ctrl_pkg::S_ILLEGAL1,
            ctrl_pkg::S_LOAD_MISALIGN1,
            ctrl_pkg::S_STORE_MISALIGN1,
            ctrl_pkg::S_LOAD_FAULT1,
            ctrl_pkg::S_STORE_FAULT1: begin
                ctrl.pc_update     = 1'b1;  // jump to trap vector
                ctrl.instr_retired = 1'b1;
            end
            default: ;
        endcase
    end

    // register file and memory are never written in the same state
    always_comb begin
        assert final (!(ctrl.reg_write && ctrl.mem_write))
            else $error("reg_write and mem_write both high in %s", state.name());
    end

endmodule

// File: src/multicycle_ctrl.sv
// Top level of the multicycle RV32I control unit.
// Decoder, state sequencer and control word generator behind plain ports.
// Connects to a datapath that buffers rs1/rs2, aluout, old pc and data.

`timescale 1ns/10ps
`include "ctrl_cfg.svh"

module multicycle_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CTRL_OPCODE_W-1:0] op,
    input  logic [`CTRL_FUNCT7_W-1:0] funct7,
    input  logic                     zero,
    input  logic                     mem_ready,
    input  logic                     unaligned_access_load,
    input  logic                     unaligned_access_store,
    input  logic                     access_fault,
    output ctrl_pkg::adr_src_t       adr_src,
    output logic                     fetched_instr,
    output logic                     instr_retired,
    output ctrl_pkg::alu_src_a_t     alu_src_a,
    output ctrl_pkg::alu_src_b_t     alu_src_b,
    output ctrl_pkg::alu_op_t        alu_op,
    output ctrl_pkg::result_src_t    result_src,
    output ctrl_pkg::imm_src_t       imm_src,
    output logic                     pc_update,
    output logic                     branch,
    output logic                     reg_write,
    output logic                     mem_write,
    output logic                     mem_valid,
    output logic                     exception_event,
    output logic [`CTRL_CAUSE_W-1:0] cause
);

    ctrl_pkg::ctrl_state_t state;
    ctrl_pkg::ctrl_word_t  ctrl_w;

    instr_class_if cls_if ();

    instr_decoder instr_decoder_i (
        .op      (op),
        .funct7  (funct7),
        .cls     (cls_if.decoder),
        .imm_src (imm_src)
    );

    state_sequencer state_sequencer_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .cls                    (cls_if.sequencer),
        .mem_ready              (mem_ready),
        .unaligned_access_load  (unaligned_access_load),
        .unaligned_access_store (unaligned_access_store),
        .access_fault           (access_fault),
        .state                  (state)
    );

    control_word_gen control_word_gen_i (
        .state     (state),
        .zero      (zero),
        .mem_ready (mem_ready),
        .ctrl      (ctrl_w),
        .cause     (cause)
    );

    assign adr_src         = ctrl_w.adr_src;
    assign fetched_instr   = ctrl_w.fetched_instr;
    assign instr_retired   = ctrl_w.instr_retired;
    assign alu_src_a       = ctrl_w.alu_src_a;
    assign alu_src_b       = ctrl_w.alu_src_b;
    assign alu_op          = ctrl_w.alu_op;
    assign result_src      = ctrl_w.result_src;
    assign pc_update       = ctrl_w.pc_update;
    assign branch          = ctrl_w.branch;
    assign reg_write       = ctrl_w.reg_write;
    assign mem_write       = ctrl_w.mem_write;
    assign mem_valid       = ctrl_w.mem_valid;
    assign exception_event = ctrl_w.exception_event;

endmodule

// File: verification/multicycle_ctrl_tb.sv
// Directed testbench for the multicycle RV32I control unit.
// Plays one instruction at a time through the FSM. It drives the datapath
// and memory replies, and checks every cycle from one instruction fetch
// to the next against the expected strobes, cause and length.

`timescale 1ns/10ps
`include "ctrl_cfg.svh"

module multicycle_ctrl_tb;

    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 10;
    localparam int NUM_INSTR        = 24;
    localparam int MAX_INSTR_CYCLES = 10;  // load with the longest stall, rounded up
    localparam int WATCHDOG_NS      =
        (RESET_CYCLES + 2 + NUM_INSTR * MAX_INSTR_CYCLES) * CLK_PERIOD + 200;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic [`CTRL_OPCODE_W-1:0] op;
    logic [`CTRL_FUNCT7_W-1:0] funct7;
    logic                      zero;
    logic                      mem_ready;
    logic                      unaligned_access_load;
    logic                      unaligned_access_store;
    logic                      access_fault;
    ctrl_pkg::adr_src_t        adr_src;
    logic                      fetched_instr;
    logic                      instr_retired;
    ctrl_pkg::alu_src_a_t      alu_src_a;
    ctrl_pkg::alu_src_b_t      alu_src_b;
    ctrl_pkg::alu_op_t         alu_op;
    ctrl_pkg::result_src_t     result_src;
    ctrl_pkg::imm_src_t        imm_src;
    logic                      pc_update;
    logic                      branch;
    logic                      reg_write;
    logic                      mem_write;
    logic                      mem_valid;
    logic                      exception_event;
    logic [`CTRL_CAUSE_W-1:0]  cause;
    integer                    seed;

    multicycle_ctrl multicycle_ctrl_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("Fail %0t: %s", $time, msg);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // fetch state with mem_ready low: only the memory request is up
    task automatic check_idle_outputs(input string when);
        check(!reg_write && !mem_write && !pc_update && !exception_event && !instr_retired,
              $sformatf("%s: a write, pc or trap strobe is high", when));
        check(mem_valid === 1'b1, $sformatf("%s: mem_valid is not high", when));
    endtask

    // instruction read at pc, pc <- pc + 4
    task automatic check_fetch_controls(input string name);
        check(adr_src == ctrl_pkg::ADR_PC && mem_valid === 1'b1,
              $sformatf("%s: fetch reads memory at adr_src %0d", name, adr_src));
        check(alu_src_a == ctrl_pkg::SRCA_PC && alu_src_b == ctrl_pkg::SRCB_CONST_4 &&
              alu_op == ctrl_pkg::ALU_OP_ADD,
              $sformatf("%s: fetch alu a %0d b %0d op %0d, expected pc + 4", name,
                        alu_src_a, alu_src_b, alu_op));
        check(pc_update === 1'b1 && result_src == ctrl_pkg::RESULT_ALURESULT,
              $sformatf("%s: fetch pc_update %b result_src %0d", name, pc_update,
                        result_src));
    endtask

    // starts right after a cycle with fetched_instr high, ends on the next one
    task automatic run_instr(
        input logic [`CTRL_OPCODE_W-1:0] op_v,
        input logic [`CTRL_FUNCT7_W-1:0] f7_v,
        input logic                      zero_v,
        input logic                      ual_v,
        input logic                      uas_v,
        input logic                      af_v,
        input int                        stall,
        input int                        base_len,
        input int                        exp_rw,
        input int                        exp_pcu,
        input logic [`CTRL_CAUSE_W-1:0]  exp_cause,
        input ctrl_pkg::result_src_t     exp_rs,
        input ctrl_pkg::imm_src_t        exp_imm,
        input string                     name
    );
        int   idx;
        int   n_rw;
        int   n_mw;
        int   n_ret;
        int   n_pcu;
        int   n_exc;
        int   n_br;
        int   exp_mw;
        logic prev_exc;
        logic done;
        idx      = 0;
        n_rw     = 0;
        n_mw     = 0;
        n_ret    = 0;
        n_pcu    = 0;
        n_exc    = 0;
        n_br     = 0;
        prev_exc = 1'b0;
        done     = 1'b0;
        // a store that reaches memory holds mem_write through every stall
        exp_mw = (op_v == ctrl_pkg::OP_STORE && !af_v && !uas_v) ? stall + 1 : 0;
        while (!done) begin
            idx = idx + 1;
            @(posedge clk);
            op                     <= op_v;
            funct7                 <= f7_v;
            zero                   <= zero_v;
            unaligned_access_load  <= ual_v;
            unaligned_access_store <= uas_v;
            access_fault           <= af_v;
            mem_ready              <= !(idx >= 3 && idx < 3 + stall);  // memory state from idx 3
            @(negedge clk);
            check(imm_src == exp_imm,
                  $sformatf("%s: imm_src %0d, expected %0d", name, imm_src, exp_imm));
            if (fetched_instr) begin
                done = 1'b1;
                check_fetch_controls(name);
            end else begin
                if (prev_exc)
                    check(pc_update && instr_retired,
                          $sformatf("%s: no pc_update and instr_retired after trap", name));
                check(cause == (exception_event ? exp_cause : '0),
                      $sformatf("%s: cause %0d with exception_event %b", name, cause,
                                exception_event));
                if (reg_write)
                    check(result_src == exp_rs,
                          $sformatf("%s: result_src %0d, expected %0d", name, result_src, exp_rs));
                if (mem_write)
                    check(instr_retired == mem_ready,
                          $sformatf("%s: store retired before the write landed", name));
                if (branch)
                    check(mem_valid == zero_v,
                          $sformatf("%s: mem_valid %b with zero %b", name, mem_valid, zero_v));
                n_rw     = n_rw + reg_write;
                n_mw     = n_mw + mem_write;
                n_ret    = n_ret + instr_retired;
                n_pcu    = n_pcu + pc_update;
                n_exc    = n_exc + exception_event;
                n_br     = n_br + branch;
                prev_exc = exception_event;
            end
        end
        check(idx == base_len + stall,
              $sformatf("%s: %0d cycles fetch to fetch, expected %0d", name, idx, base_len + stall));
        check(n_rw == exp_rw, $sformatf("%s: %0d reg_write cycles, expected %0d", name, n_rw, exp_rw));
        check(n_mw == exp_mw, $sformatf("%s: %0d mem_write cycles, expected %0d", name, n_mw, exp_mw));
        check(n_ret == (op_v == ctrl_pkg::OP_FENCE ? 0 : 1),
              $sformatf("%s: %0d instr_retired pulses", name, n_ret));
        check(n_pcu == exp_pcu, $sformatf("%s: %0d pc_update cycles, expected %0d", name, n_pcu, exp_pcu));
        check(n_exc == (exp_cause != '0), $sformatf("%s: %0d exception_event cycles", name, n_exc));
        check(n_br == (op_v == ctrl_pkg::OP_BRANCH),
              $sformatf("%s: %0d branch cycles", name, n_br));
    endtask

    task automatic test_alu_and_fence;
        run_instr(ctrl_pkg::OP_RTYPE, 7'h00, 0, 0, 0, 0, 0, 4, 1, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_R, "add");
        run_instr(ctrl_pkg::OP_RTYPE, 7'h20, 0, 0, 0, 0, 0, 4, 1, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_R, "sub");
        run_instr(ctrl_pkg::OP_ITYPE, 7'h00, 0, 0, 0, 0, 0, 4, 1, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_I, "addi");
        run_instr(ctrl_pkg::OP_LUI, 7'h00, 0, 0, 0, 0, 0, 4, 1, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_U, "lui");
        run_instr(ctrl_pkg::OP_AUIPC, 7'h00, 0, 0, 0, 0, 0, 4, 1, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_U, "auipc");
        run_instr(ctrl_pkg::OP_FENCE, 7'h00, 0, 0, 0, 0, 0, 2, 0, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_R, "fence");
    endtask

    task automatic test_memory_stalls;
        int stall;
        repeat (3) begin
            stall = {$random(seed)} % 5;
            run_instr(ctrl_pkg::OP_LOAD, 7'h00, 0, 0, 0, 0, stall, 5, 1, 0, '0,
                      ctrl_pkg::RESULT_DATA, ctrl_pkg::IMM_I, "load");
            stall = {$random(seed)} % 5;
            run_instr(ctrl_pkg::OP_STORE, 7'h00, 0, 0, 0, 0, stall, 4, 0, 0, '0,
                      ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_S, "store");
        end
    endtask

    task automatic test_branch_and_jumps;
        run_instr(ctrl_pkg::OP_BRANCH, 7'h00, 0, 0, 0, 0, 0, 3, 0, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_B, "branch zero=0");
        run_instr(ctrl_pkg::OP_BRANCH, 7'h00, 1, 0, 0, 0, 0, 3, 0, 0, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_B, "branch zero=1");
        run_instr(ctrl_pkg::OP_JAL, 7'h00, 0, 0, 0, 0, 0, 4, 1, 1, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_J, "jal");
        run_instr(ctrl_pkg::OP_JALR, 7'h00, 0, 0, 0, 0, 0, 5, 1, 1, '0,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_I, "jalr");
    endtask

    // memory traps pass through the address state, so one cycle longer
    task automatic test_traps;
        run_instr(7'b111_1111, 7'h00, 0, 0, 0, 0, 0, 4, 0, 1, ctrl_pkg::CAUSE_ILLEGAL,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_R, "unknown opcode");
        run_instr(ctrl_pkg::OP_RTYPE, 7'h01, 0, 0, 0, 0, 0, 4, 0, 1, ctrl_pkg::CAUSE_ILLEGAL,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_R, "mul");
        run_instr(ctrl_pkg::OP_LOAD, 7'h00, 0, 1, 0, 0, 0, 5, 0, 1, ctrl_pkg::CAUSE_LOAD_MISALIGN,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_I, "misaligned load");
        run_instr(ctrl_pkg::OP_STORE, 7'h00, 0, 0, 1, 0, 0, 5, 0, 1, ctrl_pkg::CAUSE_STORE_MISALIGN,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_S, "misaligned store");
        run_instr(ctrl_pkg::OP_LOAD, 7'h00, 0, 0, 0, 1, 0, 5, 0, 1, ctrl_pkg::CAUSE_LOAD_FAULT,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_I, "load fault");
        run_instr(ctrl_pkg::OP_STORE, 7'h00, 0, 0, 0, 1, 0, 5, 0, 1, ctrl_pkg::CAUSE_STORE_FAULT,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_S, "store fault");
        run_instr(ctrl_pkg::OP_LOAD, 7'h00, 0, 1, 0, 1, 0, 5, 0, 1, ctrl_pkg::CAUSE_LOAD_FAULT,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_I, "misaligned load fault");
        run_instr(ctrl_pkg::OP_STORE, 7'h00, 0, 0, 1, 1, 0, 5, 0, 1, ctrl_pkg::CAUSE_STORE_FAULT,
                  ctrl_pkg::RESULT_ALUOUT, ctrl_pkg::IMM_S, "misaligned store fault");
    endtask

    initial begin
        seed                   = 20;
        rst_n                  = 1'b0;
        op                     = '0;
        funct7                 = '0;
        zero                   = 1'b0;
        mem_ready              = 1'b0;  // keeps pc_update low in fetch
        unaligned_access_load  = 1'b0;
        unaligned_access_store = 1'b0;
        access_fault           = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle_outputs("first cycle after reset");
        @(posedge clk);
        mem_ready <= 1'b1;
        @(negedge clk);
        check(fetched_instr === 1'b1, "no instruction fetch after reset");
        check_fetch_controls("first fetch");
        test_alu_and_fence();
        test_memory_stalls();
        test_branch_and_jumps();
        test_traps();
        $display("No errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests hung, the next instruction fetch never came");
        $display("Errors found");
        $fatal(1);
    end

endmodule

// File: filelist.f
+incdir+src
src/ctrl_pkg.sv
src/instr_class_if.sv
src/instr_decoder.sv
src/state_sequencer.sv
src/control_word_gen.sv
src/multicycle_ctrl.sv
verification/multicycle_ctrl_tb.sv
